// ==== dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and register width
`define XLEN            32

// 8-byte blocks
`define DC_BO           3

// direct-mapped main cache
`define N_IDX_BITS      4
`define N_CL            16
`define DC_TAG_LEN      (`XLEN - `N_IDX_BITS - `DC_BO)

// fully-associative victim cache
`define N_VC_CL         4
`define VC_LRU_BITS     2

`define MEM_TAG_BITS    4   // memory response tag, zero means no response

`endif

// ==== dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // one block seen as bytes, halves or words
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
    } cache_block_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;

    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;

    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;

    typedef enum logic [1:0] {READY, FETCH, WAIT_DATA, WRITEBACK} cache_state_t;

    // write a sized value into a block at the byte offset
    function automatic cache_block_t store_merge(cache_block_t block,
                                                 logic [`DC_BO-1:0] offset,
                                                 mem_size_t size,
                                                 logic [`XLEN-1:0] data);
        cache_block_t merged;
        merged = block;
        case (size)
            BYTE:    merged.byte_level[offset] = data[7:0];
            HALF:    merged.half_level[offset[`DC_BO-1:1]] = data[15:0];
            default: merged.word_level[offset[`DC_BO-1]] = data;
        endcase
        return merged;
    endfunction

    // sized field at the offset, zero-extended
    function automatic logic [`XLEN-1:0] load_extract(cache_block_t block,
                                                      logic [`DC_BO-1:0] offset,
                                                      mem_size_t size);
        logic [`XLEN-1:0] value;
        value = '0;
        case (size)
            BYTE:    value[7:0]  = block.byte_level[offset];
            HALF:    value[15:0] = block.half_level[offset[`DC_BO-1:1]];
            default: value       = block.word_level[offset[`DC_BO-1]];
        endcase
        return value;
    endfunction

endpackage

// ==== main_cache.sv ====
`include "dcache_consts.svh"

module main_cache import dcache_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                access,     // accepted request this cycle
    input  logic                fill,       // memory data for the held miss
    input  logic [`XLEN-1:0]    cur_addr,
    input  mem_op_t             cur_op,
    input  mem_size_t           cur_size,
    input  logic [`XLEN-1:0]    cur_wdata,
    input  cache_block_t        fill_block,
    output logic                main_hit,
    output cache_block_t        main_block,
    output logic                evict_valid,
    output logic [`XLEN-1:0]    evict_addr,
    output cache_block_t        evict_block,
    output logic                evict_dirty
);

    logic [`N_CL-1:0]               line_valid;
    logic [`N_CL-1:0]               line_dirty;
    logic [`DC_TAG_LEN-1:0]         line_tag   [`N_CL];
    cache_block_t                   line_block [`N_CL];

    logic [`N_IDX_BITS-1:0]         idx;
    logic [`DC_TAG_LEN-1:0]         tag;
    logic                           is_store;
    logic                           store_hit;
    cache_block_t                   fill_merged;

    assign idx = cur_addr[`N_IDX_BITS+`DC_BO-1:`DC_BO];
    assign tag = cur_addr[`XLEN-1:`N_IDX_BITS+`DC_BO];
    assign is_store = cur_op == MEM_WRITE;

    // lookup in the same cycle
    assign main_hit   = line_valid[idx] && line_tag[idx] == tag;
    assign main_block = line_block[idx];
    assign store_hit  = access && main_hit && is_store;

    // the line at this index leaves when the fill overwrites it
    assign evict_valid = fill && line_valid[idx];
    assign evict_addr  = {line_tag[idx], idx, {`DC_BO{1'b0}}};
    assign evict_block = line_block[idx];
    assign evict_dirty = line_dirty[idx];

    // write-allocate, the pending store lands in the fetched line
    assign fill_merged = is_store ?
                         store_merge(fill_block, cur_addr[`DC_BO-1:0], cur_size, cur_wdata) :
                         fill_block;

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (fill) begin
            line_valid[idx] <= 1'b1;
            line_dirty[idx] <= is_store;    // clean unless a store allocated it
        end else if (store_hit) begin
            line_dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            line_tag[idx]   <= tag;
            line_block[idx] <= fill_merged;
        end else if (store_hit) begin
            line_block[idx] <= store_merge(main_block, cur_addr[`DC_BO-1:0], cur_size,
                                           cur_wdata);
        end
    end

endmodule

// ==== victim_cache.sv ====
`include "dcache_consts.svh"

module victim_cache import dcache_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                access,
    input  logic [`XLEN-1:0]    cur_addr,
    input  mem_op_t             cur_op,
    input  mem_size_t           cur_size,
    input  logic [`XLEN-1:0]    cur_wdata,
    input  logic                evict_valid,    // line pushed out of the main cache
    input  logic [`XLEN-1:0]    evict_addr,
    input  cache_block_t        evict_block,
    input  logic                evict_dirty,
    output logic                vc_hit,
    output cache_block_t        vc_block,
    output logic                wb_valid,       // dirty line replaced, goes to memory
    output logic [`XLEN-1:0]    wb_addr,
    output cache_block_t        wb_block
);

    logic [`N_VC_CL-1:0]            line_valid;
    logic [`N_VC_CL-1:0]            line_dirty;
    logic [`VC_LRU_BITS-1:0]        line_lru   [`N_VC_CL];
    logic [`XLEN-`DC_BO-1:0]        line_tag   [`N_VC_CL];  // full block address
    cache_block_t                   line_block [`N_VC_CL];

    logic [$clog2(`N_VC_CL)-1:0]    hit_idx;
    logic [$clog2(`N_VC_CL)-1:0]    free_idx;
    logic                           free_found;
    logic [$clog2(`N_VC_CL)-1:0]    lru_idx;
    logic [`VC_LRU_BITS-1:0]        lru_min;
    logic [$clog2(`N_VC_CL)-1:0]    ins_idx;
    logic                           store_hit;

    always_comb begin
        vc_hit  = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `N_VC_CL; i++) begin
            if (line_valid[i] && line_tag[i] == cur_addr[`XLEN-1:`DC_BO]) begin
                vc_hit  = 1'b1;
                hit_idx = i[$clog2(`N_VC_CL)-1:0];
            end
        end
    end

    assign vc_block  = line_block[hit_idx];
    assign store_hit = access && vc_hit && cur_op == MEM_WRITE;

    // lowest free entry, and the entry with the smallest counter
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        lru_idx    = '0;
        lru_min    = line_lru[0];
        for (int i = `N_VC_CL - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_found = 1'b1;
                free_idx   = i[$clog2(`N_VC_CL)-1:0];
            end
        end
        for (int i = 1; i < `N_VC_CL; i++) begin
            if (line_lru[i] < lru_min) begin    // ties keep the lower index
                lru_min = line_lru[i];
                lru_idx = i[$clog2(`N_VC_CL)-1:0];
            end
        end
    end

    assign ins_idx = free_found ? free_idx : lru_idx;

    // only reached when full, so the replaced entry is valid
    assign wb_valid = evict_valid && !free_found && line_dirty[lru_idx];
    assign wb_addr  = {line_tag[lru_idx], {`DC_BO{1'b0}}};
    assign wb_block = line_block[lru_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
            for (int i = 0; i < `N_VC_CL; i++) begin
                line_lru[i] <= '0;
            end
        end else if (evict_valid) begin
            line_valid[ins_idx] <= 1'b1;
            line_dirty[ins_idx] <= evict_dirty;
            line_lru[ins_idx]   <= '0;          // newcomer starts oldest
        end else if (access && vc_hit) begin
            for (int i = 0; i < `N_VC_CL; i++) begin
                if (i == hit_idx) begin
                    line_lru[i] <= '1;
                end else if (line_lru[i] != '0) begin
                    line_lru[i] <= line_lru[i] - 1'b1;
                end
            end
            if (store_hit) begin
                line_dirty[hit_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (evict_valid) begin
            line_tag[ins_idx]   <= evict_addr[`XLEN-1:`DC_BO];
            line_block[ins_idx] <= evict_block;
        end else if (store_hit) begin
            line_block[hit_idx] <= store_merge(vc_block, cur_addr[`DC_BO-1:0], cur_size,
                                               cur_wdata);
        end
    end

endmodule

// ==== miss_control.sv ====
`include "dcache_consts.svh"

module miss_control import dcache_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  mem_op_t                     req_op,
    input  mem_size_t                   req_size,
    input  logic [`XLEN-1:0]            req_addr,
    input  logic [`XLEN-1:0]            req_wdata,
    input  logic                        main_hit,
    input  cache_block_t                main_block,
    input  logic                        vc_hit,
    input  cache_block_t                vc_block,
    input  logic                        wb_valid,
    input  logic [`XLEN-1:0]            wb_addr,
    input  cache_block_t                wb_block,
    input  logic [`MEM_TAG_BITS-1:0]    mem_response,
    input  logic [`MEM_TAG_BITS-1:0]    mem_tag,
    input  cache_block_t                mem_rdata,
    output logic                        stall,
    output logic                        access,
    output logic                        fill,
    output cache_block_t                fill_block,
    output logic [`XLEN-1:0]            cur_addr,
    output mem_op_t                     cur_op,
    output mem_size_t                   cur_size,
    output logic [`XLEN-1:0]            cur_wdata,
    output logic                        resp_valid,
    output logic [`XLEN-1:0]            resp_data,
    output bus_cmd_t                    mem_command,
    output logic [`XLEN-1:0]            mem_addr,
    output cache_block_t                mem_data
);

    cache_state_t               state;
    cache_state_t               state_next;
    logic [`XLEN-1:0]           hold_addr;      // the missing request
    mem_op_t                    hold_op;
    mem_size_t                  hold_size;
    logic [`XLEN-1:0]           hold_wdata;
    logic [`MEM_TAG_BITS-1:0]   issued_tag;
    logic [`XLEN-1:0]           wb_addr_q;      // one-line write-back buffer
    cache_block_t               wb_block_q;
    logic                       hit;
    logic                       miss;
    logic                       taken;
    logic                       respond;
    cache_block_t               resp_block;

    assign stall  = state != READY;
    assign access = req_valid && state == READY;
    assign hit    = main_hit || vc_hit;
    assign miss   = access && !hit;
    assign taken  = mem_response != '0;     // command accepted by memory

    assign fill       = state == WAIT_DATA && mem_tag == issued_tag;
    assign fill_block = mem_rdata;

    // incoming request while ready, the held one during a miss
    assign cur_addr  = (state == READY) ? req_addr  : hold_addr;
    assign cur_op    = (state == READY) ? req_op    : hold_op;
    assign cur_size  = (state == READY) ? req_size  : hold_size;
    assign cur_wdata = (state == READY) ? req_wdata : hold_wdata;

    always_comb begin
        state_next = state;
        case (state)
            READY:     if (miss) state_next = FETCH;
            FETCH:     if (taken) state_next = WAIT_DATA;
            WAIT_DATA: if (fill) state_next = wb_valid ? WRITEBACK : READY;
            WRITEBACK: if (taken) state_next = READY;
            default:   state_next = READY;
        endcase
    end

    always_comb begin
        mem_command = BUS_NONE;
        mem_addr    = {hold_addr[`XLEN-1:`DC_BO], {`DC_BO{1'b0}}};
        mem_data    = wb_block_q;
        case (state)
            FETCH: mem_command = BUS_LOAD;
            WRITEBACK: begin
                mem_command = BUS_STORE;
                mem_addr    = wb_addr_q;
            end
            default: mem_command = BUS_NONE;
        endcase
    end

    // the fill data has priority, no lookup hits while waiting
    assign respond    = (access && hit) || fill;
    assign resp_block = fill ? mem_rdata : (main_hit ? main_block : vc_block);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= READY;
            issued_tag <= '0;
            resp_valid <= 1'b0;
        end else begin
            state      <= state_next;
            resp_valid <= respond;
            if (state == FETCH && taken) begin
                issued_tag <= mem_response;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss) begin
            hold_addr  <= req_addr;
            hold_op    <= req_op;
            hold_size  <= req_size;
            hold_wdata <= req_wdata;
        end
        if (fill && wb_valid) begin
            wb_addr_q  <= wb_addr;
            wb_block_q <= wb_block;
        end
        if (respond) begin
            resp_data <= load_extract(resp_block, cur_addr[`DC_BO-1:0], cur_size);
        end
    end

endmodule

// ==== dcache.sv ====
`include "dcache_consts.svh"

module dcache import dcache_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    // pipeline side
    input  logic                        req_valid,
    input  mem_op_t                     req_op,
    input  mem_size_t                   req_size,
    input  logic [`XLEN-1:0]            req_addr,
    input  logic [`XLEN-1:0]            req_wdata,
    output logic                        stall,
    output logic                        resp_valid,
    output logic [`XLEN-1:0]            resp_data,
    // memory side
    output bus_cmd_t                    mem_command,
    output logic [`XLEN-1:0]            mem_addr,
    output cache_block_t                mem_data,
    input  logic [`MEM_TAG_BITS-1:0]    mem_response,
    input  logic [`MEM_TAG_BITS-1:0]    mem_tag,
    input  cache_block_t                mem_rdata
);

    logic               access;
    logic               fill;
    cache_block_t       fill_block;
    logic [`XLEN-1:0]   cur_addr;
    mem_op_t            cur_op;
    mem_size_t          cur_size;
    logic [`XLEN-1:0]   cur_wdata;
    logic               main_hit;
    cache_block_t       main_block;
    logic               evict_valid;
    logic [`XLEN-1:0]   evict_addr;
    cache_block_t       evict_block;
    logic               evict_dirty;
    logic               vc_hit;
    cache_block_t       vc_block;
    logic               wb_valid;
    logic [`XLEN-1:0]   wb_addr;
    cache_block_t       wb_block;

    main_cache u_main_cache (
        .clock, .reset, .access, .fill, .cur_addr, .cur_op, .cur_size, .cur_wdata,
        .fill_block, .main_hit, .main_block, .evict_valid, .evict_addr, .evict_block,
        .evict_dirty
    );

    victim_cache u_victim_cache (
        .clock, .reset, .access, .cur_addr, .cur_op, .cur_size, .cur_wdata,
        .evict_valid, .evict_addr, .evict_block, .evict_dirty,
        .vc_hit, .vc_block, .wb_valid, .wb_addr, .wb_block
    );

    miss_control u_miss_control (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .main_hit, .main_block, .vc_hit, .vc_block, .wb_valid, .wb_addr, .wb_block,
        .mem_response, .mem_tag, .mem_rdata,
        .stall, .access, .fill, .fill_block, .cur_addr, .cur_op, .cur_size, .cur_wdata,
        .resp_valid, .resp_data, .mem_command, .mem_addr, .mem_data
    );

endmodule

// ==== dcache_checker.sv ====
`include "dcache_consts.svh"

module dcache_checker import dcache_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  mem_op_t                     req_op,
    input  mem_size_t                   req_size,
    input  logic [`XLEN-1:0]            req_addr,
    input  logic [`XLEN-1:0]            req_wdata,
    input  logic                        expect_hit,     // request must hit
    input  logic                        stall,
    input  logic                        resp_valid,
    input  logic [`XLEN-1:0]            resp_data,
    input  bus_cmd_t                    mem_command,
    input  logic [`XLEN-1:0]            mem_addr,
    input  cache_block_t                mem_data,
    input  logic [`MEM_TAG_BITS-1:0]    mem_response,
    output int                          value_errors,
    output int                          protocol_errors,
    output int                          pending
);

    logic [7:0]         shadow [logic [`XLEN-1:0]];    // bytes of accepted stores
    logic [`XLEN-1:0]   exp_data_q [$];
    logic               exp_load_q [$];
    logic               after_reset;
    logic               hit_due;

    function automatic logic [7:0] read_byte(logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] word;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        word = {2'b00, addr[`XLEN-1:2]} ^ 32'h5a5a0000;
        word = word >> {addr[1:0], 3'b000};
        return word[7:0];
    endfunction

    function automatic int size_bytes(mem_size_t size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [63:0] shadow_block(logic [`XLEN-1:0] addr);
        logic [63:0] block;
        for (int b = 0; b < 8; b++) begin
            block[8*b +: 8] = read_byte(addr + b);
        end
        return block;
    endfunction

    // stores update the shadow at acceptance, loads read it in order
    task automatic record_request();
        logic [`XLEN-1:0] value;
        value = '0;
        for (int b = 0; b < size_bytes(req_size); b++) begin
            if (req_op == MEM_WRITE) begin
                shadow[req_addr + b] = req_wdata[8*b +: 8];
            end else begin
                value[8*b +: 8] = read_byte(req_addr + b);
            end
        end
        exp_data_q.push_back(value);
        exp_load_q.push_back(req_op == MEM_READ);
    endtask

    always @(negedge clock) begin
        logic [`XLEN-1:0] expected;
        logic             was_load;
        if (reset) begin
            after_reset     = 1'b1;
            hit_due         = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
            exp_data_q.delete();
            exp_load_q.delete();
        end else begin
            if (after_reset && (stall || resp_valid || mem_command != BUS_NONE)) begin
                $display("time %0t: cache outputs are not idle after reset", $time);
                protocol_errors++;
            end
            after_reset = 1'b0;
            if (hit_due && (stall || !resp_valid)) begin
                $display("time %0t: a hit was not answered one cycle after acceptance", $time);
                protocol_errors++;
            end
            if (resp_valid && exp_data_q.size() == 0) begin
                $display("time %0t: resp_valid came with no request outstanding", $time);
                protocol_errors++;
            end else if (resp_valid) begin
                expected = exp_data_q.pop_front();
                was_load = exp_load_q.pop_front();
                if (was_load && resp_data !== expected) begin
                    $display("** Error at time %0t: resp_data expected %h got %h",
                             $time, expected, resp_data);
                    value_errors++;
                end
            end
            hit_due = req_valid && !stall && expect_hit;
            if (req_valid && !stall) begin
                record_request();
            end
            // a write-back must carry the latest contents of the line
            if (mem_command == BUS_STORE && mem_response != '0 &&
                mem_data !== shadow_block(mem_addr)) begin
                $display("** Error at time %0t: mem_data expected %h got %h",
                         $time, shadow_block(mem_addr), mem_data);
                value_errors++;
            end
        end
        pending = exp_data_q.size();
    end

endmodule

// ==== dcache_tb.sv ====
`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int NUM_ENTRIES = 28;
    localparam int SEED        = 21990;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + 10;
    localparam int DRIVE_DELAY = 5;

    typedef struct packed {
        mem_op_t            op;
        mem_size_t          size;
        logic [`XLEN-1:0]   addr;
        logic [`XLEN-1:0]   wdata;
        logic               hit;        // must be served one cycle after acceptance
    } stim_entry_t;

    // index 0 holds 0x100 and 0x180 while index 2 takes the six dirty lines
    stim_entry_t stim_table [NUM_ENTRIES] = '{
        '{MEM_READ,  WORD, 32'h0000_0100, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0104, 32'h0000_0000, 1'b1},
        '{MEM_WRITE, BYTE, 32'h0000_0101, 32'h0000_00ab, 1'b1},
        '{MEM_WRITE, HALF, 32'h0000_0106, 32'h0000_beef, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0100, 32'h0000_0000, 1'b1},
        '{MEM_READ,  HALF, 32'h0000_0106, 32'h0000_0000, 1'b1},
        '{MEM_READ,  BYTE, 32'h0000_0101, 32'h0000_0000, 1'b1},
        '{MEM_WRITE, WORD, 32'h0000_0208, 32'hcafe_f00d, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_020c, 32'h0000_0000, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0208, 32'h0000_0000, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0180, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0104, 32'h0000_0000, 1'b1},
        '{MEM_WRITE, BYTE, 32'h0000_0102, 32'h0000_0077, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0100, 32'h0000_0000, 1'b1},
        '{MEM_READ,  HALF, 32'h0000_0184, 32'h0000_0000, 1'b1},
        '{MEM_WRITE, WORD, 32'h0000_0010, 32'hd000_0010, 1'b0},
        '{MEM_WRITE, WORD, 32'h0000_0090, 32'hd000_0090, 1'b0},
        '{MEM_WRITE, WORD, 32'h0000_0110, 32'hd000_0110, 1'b0},
        '{MEM_WRITE, WORD, 32'h0000_0190, 32'hd000_0190, 1'b0},
        '{MEM_WRITE, WORD, 32'h0000_0210, 32'hd000_0210, 1'b0},
        '{MEM_WRITE, WORD, 32'h0000_0290, 32'hd000_0290, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0010, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0090, 32'h0000_0000, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0110, 32'h0000_0000, 1'b1},
        '{MEM_READ,  WORD, 32'h0000_0190, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0210, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0290, 32'h0000_0000, 1'b0},
        '{MEM_READ,  WORD, 32'h0000_0100, 32'h0000_0000, 1'b1}
    };

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       req_valid;
    mem_op_t                    req_op;
    mem_size_t                  req_size;
    logic [`XLEN-1:0]           req_addr;
    logic [`XLEN-1:0]           req_wdata;
    logic                       expect_hit;
    logic                       stall;
    logic                       resp_valid;
    logic [`XLEN-1:0]           resp_data;
    bus_cmd_t                   mem_command;
    logic [`XLEN-1:0]           mem_addr;
    cache_block_t               mem_data;
    logic [`MEM_TAG_BITS-1:0]   mem_response;
    logic [`MEM_TAG_BITS-1:0]   mem_tag;
    cache_block_t               mem_rdata;
    int                         value_errors;
    int                         protocol_errors;
    int                         pending;
    int                         cycle_count = 0;

    // sparse memory model with one entry per written block
    logic [63:0]                mem_blocks [logic [`XLEN-1:0]];
    int                         accept_wait = -1;   // -1 while no command is seen
    int                         load_wait = 0;
    logic [`MEM_TAG_BITS-1:0]   load_tag;
    logic [`XLEN-1:0]           load_addr;
    logic [`MEM_TAG_BITS-1:0]   next_tag = 4'd1;

    dcache uut (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .stall, .resp_valid, .resp_data, .mem_command, .mem_addr, .mem_data,
        .mem_response, .mem_tag, .mem_rdata
    );

    dcache_checker u_checker (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata, .expect_hit,
        .stall, .resp_valid, .resp_data, .mem_command, .mem_addr, .mem_data, .mem_response,
        .value_errors, .protocol_errors, .pending
    );

    always #50 clock = ~clock;

    // unwritten word at word address A holds A ^ 5a5a0000
    function automatic logic [63:0] read_block(logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] word_addr;
        word_addr = {2'b00, addr[`XLEN-1:2]};
        if (mem_blocks.exists(addr)) begin
            return mem_blocks[addr];
        end
        return {(word_addr + 32'd1) ^ 32'h5a5a0000, word_addr ^ 32'h5a5a0000};
    endfunction

    task automatic serve_memory();
        mem_response = '0;
        mem_tag      = '0;
        if (load_wait > 0) begin
            load_wait--;
            if (load_wait == 0) begin
                mem_tag   = load_tag;       // data for the outstanding load
                mem_rdata = read_block(load_addr);
            end
        end
        if (mem_command != BUS_NONE) begin
            if (accept_wait < 0) begin
                accept_wait = $urandom % 4;
            end
            if (accept_wait == 0) begin
                mem_response = next_tag;
                if (mem_command == BUS_STORE) begin
                    mem_blocks[mem_addr] = mem_data;
                end else begin
                    load_tag  = next_tag;
                    load_addr = mem_addr;
                    load_wait = 2 + $urandom % 4;
                end
                next_tag    = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                accept_wait = -1;
            end else begin
                accept_wait--;
            end
        end
    endtask

    initial begin
        mem_response = '0;
        mem_tag      = '0;
        mem_rdata    = '0;
        forever begin
            @(posedge clock);
            #DRIVE_DELAY;
            serve_memory();
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int seed_init;
        seed_init  = $urandom(SEED);
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_op     = MEM_READ;
        req_size   = WORD;
        req_addr   = '0;
        req_wdata  = '0;
        expect_hit = 1'b0;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            while (stall) begin
                @(posedge clock);
                #DRIVE_DELAY;
            end
            req_valid  = 1'b1;
            req_op     = stim_table[i].op;
            req_size   = stim_table[i].size;
            req_addr   = stim_table[i].addr;
            req_wdata  = stim_table[i].wdata;
            expect_hit = stim_table[i].hit;
            @(posedge clock);       // accepted here as stall was low
            #DRIVE_DELAY;
            req_valid  = 1'b0;
            expect_hit = 1'b0;
        end
        while (pending != 0 || stall) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        repeat (4) @(posedge clock);    // room for any stray response
        $display("errors: %0d data mismatches, %0d protocol failures",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== dcache.f ====
+incdir+.
dcache_pkg.sv
main_cache.sv
victim_cache.sv
miss_control.sv
dcache.sv
dcache_checker.sv
dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
verilator --binary --timing --top-module dcache_tb -f dcache.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
